// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - rv_decoder.sv
      - rv_regfile.sv
      - rv_alu.sv
      - rv_hazard_unit.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

// File: compile.f
+incdir+.
rv_core_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_hazard_unit.sv
rv_core.sv
tb_rv_core.sv

// File: rv_alu.sv
/*
 * Integer ALU, ten RV32I operations
 *   shifts take the low five bits of b
 */

`default_nettype none

module rv_alu (
    input  var rv_core_pkg::alu_op_e op,
    input  var rv_core_pkg::word_t   a,
    input  var rv_core_pkg::word_t   b,
    output rv_core_pkg::word_t       result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::ALU_ADD:  result = a + b;
            rv_core_pkg::ALU_SUB:  result = a - b;
            rv_core_pkg::ALU_SLL:  result = a << shamt;
            rv_core_pkg::ALU_SLT:  result = rv_core_pkg::word_t'($signed(a) < $signed(b));
            rv_core_pkg::ALU_SLTU: result = rv_core_pkg::word_t'(a < b);
            rv_core_pkg::ALU_XOR:  result = a ^ b;
            rv_core_pkg::ALU_SRL:  result = a >> shamt;
            rv_core_pkg::ALU_SRA:  result = $signed(a) >>> shamt;  // Sign bit fills
            rv_core_pkg::ALU_OR:   result = a | b;
            rv_core_pkg::ALU_AND:  result = a & b;
            default:               result = a + b;  // Unused codes behave as ADD
        endcase
    end

endmodule

`default_nettype wire

// File: rv_core.sv
/*
 * Five-stage in-order RV32I pipeline, top level
 *   PC and IF/ID, ID/EX, EX/MEM, MEM/WB registers
 *   forward and immediate operand muxes, writeback mux
 *   instruction and data memory ports
 */

`default_nettype none

`include "rv_core_config.svh"

module rv_core (
    input  var logic               clk,
    input  var logic               rst,
    // Instruction memory, answers in the same cycle
    output rv_core_pkg::word_t     imem_addr,
    input  var rv_core_pkg::word_t imem_data,
    // Data memory, read data valid in the same cycle
    output logic                   dmem_read,
    output logic                   dmem_write,
    output rv_core_pkg::word_t     dmem_addr,
    output rv_core_pkg::word_t     dmem_wdata,
    input  var rv_core_pkg::word_t dmem_rdata
);

    rv_core_pkg::word_t   pc;
    rv_core_pkg::if_id_t  if_id;
    rv_core_pkg::id_ex_t  id_ex;
    rv_core_pkg::ex_mem_t ex_mem;
    rv_core_pkg::mem_wb_t mem_wb;

    logic                  stall;           // Load-use, one cycle
    rv_core_pkg::fwd_sel_e fwd_a;
    rv_core_pkg::fwd_sel_e fwd_b;
    rv_core_pkg::word_t    wb_data;

    // Pick the newest copy of an execute operand
    function automatic rv_core_pkg::word_t fwd_mux(input rv_core_pkg::fwd_sel_e sel,
                                                   input rv_core_pkg::word_t reg_val,
                                                   input rv_core_pkg::word_t ex_val,
                                                   input rv_core_pkg::word_t wb_val);
        case (sel)
            rv_core_pkg::FWD_EX_MEM: return ex_val;
            rv_core_pkg::FWD_MEM_WB: return wb_val;
            default:                 return reg_val;
        endcase
    endfunction

    // ============================================================
    // Fetch
    // ============================================================
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= `RV_RESET_PC;
            if_id <= '0;                     // Zero word decodes as a bubble
        end else if (!stall) begin           // Both hold while decode waits
            pc          <= pc + 32'd4;       // No control flow, always sequential
            if_id.instr <= imem_data;
        end
    end

    // ============================================================
    // Decode
    // ============================================================
    rv_core_pkg::reg_idx_t id_rs1, id_rs2, id_rd;
    rv_core_pkg::ctrl_t    id_ctrl;
    rv_core_pkg::word_t    id_imm;
    rv_core_pkg::word_t    id_rs1_data, id_rs2_data;

    assign id_rd  = if_id.instr[11:7];
    assign id_rs1 = if_id.instr[19:15];
    assign id_rs2 = if_id.instr[24:20];

    rv_decoder u_decoder (
        .instr (if_id.instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .we     (mem_wb.reg_write),
        .waddr  (mem_wb.rd),
        .wdata  (wb_data),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (id_rs1_data),
        .rdata2 (id_rs2_data)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0;                     // Bubble while the load finishes
        end else begin
            id_ex.ctrl     <= id_ctrl;
            id_ex.rs1_data <= id_rs1_data;
            id_ex.rs2_data <= id_rs2_data;
            id_ex.imm      <= id_imm;
            id_ex.rd       <= id_rd;
            id_ex.rs1      <= id_rs1;
            id_ex.rs2      <= id_rs2;
        end
    end

    // ============================================================
    // Execute
    // ============================================================
    rv_core_pkg::word_t ex_a, ex_b_fwd, ex_b, ex_result;

    rv_hazard_unit u_hazard (
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .ex_rs1        (id_ex.rs1),
        .ex_rs2        (id_ex.rs2),
        .ex_rd         (id_ex.rd),
        .mem_rd        (ex_mem.rd),
        .wb_rd         (mem_wb.rd),
        .ex_mem_read   (id_ex.ctrl.mem_read),
        .mem_reg_write (ex_mem.ctrl.reg_write),
        .wb_reg_write  (mem_wb.reg_write),
        .stall         (stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    assign ex_a     = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb_data);
    assign ex_b_fwd = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb_data);
    assign ex_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : ex_b_fwd;

    rv_alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= ex_result;
            ex_mem.store_data <= ex_b_fwd;   // SW data needs forwarding too
            ex_mem.rd         <= id_ex.rd;
        end
    end

    // ============================================================
    // Memory and writeback
    // ============================================================
    assign dmem_read  = ex_mem.ctrl.mem_read;
    assign dmem_write = ex_mem.ctrl.mem_write;
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.mem_data   <= dmem_rdata;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    // Loads write memory data, everything else the ALU result
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

endmodule

`default_nettype wire

// File: rv_core_config.svh
/*
 * Build parameters of the RV32I pipeline
 *   data and address width, register count,
 *   register index width and reset PC
 */

`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data, address and instruction width
`define RV_XLEN       32

// Architectural registers, x0 included
`define RV_NREGS      32
`define RV_REG_IDX_W  5     // log2 of RV_NREGS

// First fetch address after reset
`define RV_RESET_PC   32'h0000_0000

`endif

// File: rv_core_pkg.sv
/*
 * Shared types of the RV32I pipeline
 *   word and register index typedefs
 *   opcode and funct constants
 *   ALU operation and forward select enums
 *   control word and the four pipeline register structs
 */

`default_nettype none

`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]      word_t;     // Data, address or instruction
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;  // Register index

    // ============================================================
    // Encodings
    // ============================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB and SRA/SRAI

    // Zero value is ADD so a cleared control word is harmless
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG    = 2'b00,  // Operand read in decode
        FWD_MEM_WB = 2'b01,  // Writeback value
        FWD_EX_MEM = 2'b10   // ALU result one stage ahead
    } fwd_sel_e;

    // ============================================================
    // Pipeline registers
    // ============================================================

    // All-zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;  // B operand is the immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;   // Writeback takes load data
    } ctrl_t;

    typedef struct packed {
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;  // Also the data address
        word_t    store_data;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        word_t    alu_result;
        word_t    mem_data;
        reg_idx_t rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rv_decoder.sv
/*
 * Instruction decoder
 *   opcode, funct3 and funct7 to control word
 *   I-type or S-type sign-extended immediate
 *   unsupported opcodes give a bubble
 */

`default_nettype none

module rv_decoder (
    input  var rv_core_pkg::word_t instr,
    output rv_core_pkg::ctrl_t     ctrl,
    output rv_core_pkg::word_t     imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;       // funct7 selects SUB or SRA

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = (funct7 == rv_core_pkg::F7_ALT);

    // funct3 to ALU op, alt picks the second flavour of 000 and 101
    function automatic rv_core_pkg::alu_op_e alu_decode(input logic [2:0] f3,
                                                        input logic       use_alt);
        case (f3)
            rv_core_pkg::F3_ADD_SUB:
                return use_alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            rv_core_pkg::F3_SLL:  return rv_core_pkg::ALU_SLL;
            rv_core_pkg::F3_SLT:  return rv_core_pkg::ALU_SLT;
            rv_core_pkg::F3_SLTU: return rv_core_pkg::ALU_SLTU;
            rv_core_pkg::F3_XOR:  return rv_core_pkg::ALU_XOR;
            rv_core_pkg::F3_SRL_SRA:
                return use_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            rv_core_pkg::F3_OR:   return rv_core_pkg::ALU_OR;
            default:              return rv_core_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;                                       // Bubble unless recognised
        imm  = {{20{instr[31]}}, instr[31:20]};          // I-type by default
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                ctrl.alu_op    = alu_decode(funct3, alt);
                ctrl.reg_write = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                // No SUBI, alt only matters for SRAI
                ctrl.alu_op      = alu_decode(funct3,
                                              alt && (funct3 == rv_core_pkg::F3_SRL_SRA));
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            rv_core_pkg::OPC_LOAD: begin
                ctrl.alu_op      = rv_core_pkg::ALU_ADD;  // base + offset
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            rv_core_pkg::OPC_STORE: begin
                ctrl.alu_op      = rv_core_pkg::ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S-type split field
            end
            default: ;                                   // Dropped or unknown opcode
        endcase
    end

endmodule

`default_nettype wire

// File: rv_hazard_unit.sv
/*
 * Hazard unit
 *   load-use stall towards fetch and decode
 *   forward selects for both execute operands
 */

`default_nettype none

module rv_hazard_unit (
    input  var rv_core_pkg::reg_idx_t id_rs1,
    input  var rv_core_pkg::reg_idx_t id_rs2,
    input  var rv_core_pkg::reg_idx_t ex_rs1,
    input  var rv_core_pkg::reg_idx_t ex_rs2,
    input  var rv_core_pkg::reg_idx_t ex_rd,
    input  var rv_core_pkg::reg_idx_t mem_rd,
    input  var rv_core_pkg::reg_idx_t wb_rd,
    input  var logic                  ex_mem_read,
    input  var logic                  mem_reg_write,
    input  var logic                  wb_reg_write,
    output logic                      stall,
    output rv_core_pkg::fwd_sel_e     fwd_a,
    output rv_core_pkg::fwd_sel_e     fwd_b
);

    // EX/MEM wins over MEM/WB, x0 is never forwarded
    function automatic rv_core_pkg::fwd_sel_e pick_fwd(input rv_core_pkg::reg_idx_t src,
                                                       input logic m_we,
                                                       input rv_core_pkg::reg_idx_t m_rd,
                                                       input logic w_we,
                                                       input rv_core_pkg::reg_idx_t w_rd);
        if (src == '0) begin
            return rv_core_pkg::FWD_REG;
        end else if (m_we && m_rd == src) begin
            return rv_core_pkg::FWD_EX_MEM;
        end else if (w_we && w_rd == src) begin
            return rv_core_pkg::FWD_MEM_WB;
        end
        return rv_core_pkg::FWD_REG;
    endfunction

    // ============================================================
    // Load-use
    // ============================================================
    // Load data only exists after the memory stage, so decode waits one cycle
    assign stall = ex_mem_read && (ex_rd != '0) &&
                   ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    // ============================================================
    // Execute forwarding
    // ============================================================
    always_comb begin
        fwd_a = pick_fwd(ex_rs1, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
        fwd_b = pick_fwd(ex_rs2, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
    end

endmodule

`default_nettype wire

// File: rv_regfile.sv
/*
 * Register file with two read ports and one write port
 *   writes to x0 are dropped so it always reads zero
 *   same-cycle write-through on both read ports
 */

`default_nettype none

`include "rv_core_config.svh"

module rv_regfile (
    input  var logic                  clk,
    input  var logic                  rst,
    input  var logic                  we,
    input  var rv_core_pkg::reg_idx_t waddr,
    input  var rv_core_pkg::word_t    wdata,
    input  var rv_core_pkg::reg_idx_t raddr1,
    input  var rv_core_pkg::reg_idx_t raddr2,
    output rv_core_pkg::word_t        rdata1,
    output rv_core_pkg::word_t        rdata2
);

    rv_core_pkg::word_t regs [`RV_NREGS];
    logic               wr_en;     // Write that actually lands

    assign wr_en = we && (waddr != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // Writeback of this cycle is visible to decode right away
    assign rdata1 = (wr_en && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wr_en && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: tb_rv_core.sv
/*
 * Testbench of the RV32I pipeline
 *   random program generator with an instruction-level model
 *   combinational instruction and data memory models
 *   reset, fetch, store and load checks
 */

`default_nettype none

`include "rv_core_config.svh"

module tb_rv_core;

    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 64;
    localparam int DUMP_BASE  = 48;       // Words 48..63 take the final register dump
    localparam int N_RANDOM   = 150;      // Random steps of one to three instructions each
    localparam int TIMEOUT    = 2000;     // Cycles for the whole program
    localparam int DRIVE_DLY  = 2;
    localparam rv_core_pkg::word_t NOP = 32'h0000_0013;   // ADDI x0, x0, 0

    logic               clk;
    logic               rst;
    rv_core_pkg::word_t imem_addr;
    rv_core_pkg::word_t imem_data;
    logic               dmem_read;
    logic               dmem_write;
    rv_core_pkg::word_t dmem_addr;
    rv_core_pkg::word_t dmem_wdata;
    rv_core_pkg::word_t dmem_rdata;

    rv_core_pkg::word_t imem [IMEM_WORDS];
    rv_core_pkg::word_t dmem [DMEM_WORDS];       // Memory seen by the DUT
    rv_core_pkg::word_t model_mem [DMEM_WORDS];  // Model's own copy
    rv_core_pkg::word_t model_reg [16];          // Program only uses x0..x15
    rv_core_pkg::word_t exp_st_addr [$];
    rv_core_pkg::word_t exp_st_data [$];
    rv_core_pkg::word_t exp_ld_addr [$];

    integer             seed;
    int                 n_instr;
    int                 n_stores;
    int                 total_stores;
    int                 value_errs;
    int                 other_errs;
    int                 hold_cnt;
    logic               mon_on;
    rv_core_pkg::word_t prev_pc;

    rv_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    // Both memories answer in the same cycle
    assign imem_data  = (imem_addr[31:2] < IMEM_WORDS) ? imem[imem_addr[11:2]] : NOP;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // Encoding and reference model
    // ============================================================
    function automatic int pick(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Op codes 0 to 9 stand for ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic rv_core_pkg::word_t ref_alu(int code, rv_core_pkg::word_t a,
                                                   rv_core_pkg::word_t b);
        case (code)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];   // Arithmetic
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(int code);
        case (code)
            0, 1:    return 3'b000;
            2:       return 3'b001;
            3:       return 3'b010;
            4:       return 3'b011;
            5:       return 3'b100;
            6, 7:    return 3'b101;
            8:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    task automatic emit(rv_core_pkg::word_t w);
        imem[n_instr] = w;
        n_instr++;
    endtask

    task automatic write_reg(int rd, rv_core_pkg::word_t v);
        if (rd != 0) model_reg[rd] = v;          // x0 stays zero
    endtask

    task automatic gen_r(int code, int rd, int rs1, int rs2);
        logic [6:0] f7;
        f7 = (code == 1 || code == 7) ? 7'b0100000 : 7'b0000000;
        emit({f7, 5'(rs2), 5'(rs1), funct3_of(code), 5'(rd), 7'b0110011});
        write_reg(rd, ref_alu(code, model_reg[rs1], model_reg[rs2]));
    endtask

    task automatic gen_i(int code, int rd, int rs1);
        logic [11:0] imm;
        if (code == 1) code = 0;                 // No SUBI
        imm = 12'(pick(4096));
        if (code == 2 || code == 6 || code == 7) // Shift amount plus SRAI flag
            imm = {(code == 7) ? 7'b0100000 : 7'b0000000, imm[4:0]};
        emit({imm, 5'(rs1), funct3_of(code), 5'(rd), 7'b0010011});
        write_reg(rd, ref_alu(code, model_reg[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic gen_lw(int rd, int widx);
        logic [11:0] off;
        off = 12'(widx * 4);
        emit({off, 5'd0, 3'b010, 5'(rd), 7'b0000011});   // LW rd, off(x0)
        exp_ld_addr.push_back(32'(widx * 4));
        write_reg(rd, model_mem[widx]);
    endtask

    task automatic gen_sw(int rs2, int widx);
        logic [11:0] off;
        off = 12'(widx * 4);
        emit({off[11:5], 5'(rs2), 5'd0, 3'b010, off[4:0], 7'b0100011});
        model_mem[widx] = model_reg[rs2];
        exp_st_addr.push_back(32'(widx * 4));
        exp_st_data.push_back(model_reg[rs2]);
    endtask

    task automatic build_program();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int last_rd;
        last_rd = 1;
        for (int k = 0; k < N_RANDOM; k++) begin
            kind = pick(10);
            rd   = pick(16);
            rs1  = (pick(2) == 0) ? last_rd : pick(16);   // Lean on the newest result
            rs2  = (pick(2) == 0) ? last_rd : pick(16);
            if (kind < 4) begin
                gen_r(pick(10), rd, rs1, rs2);
            end else if (kind < 7) begin
                gen_i(pick(10), rd, rs1);
            end else if (kind == 7) begin
                gen_lw(rd, pick(DUMP_BASE));
            end else if (kind == 8) begin
                gen_sw(rs1, pick(DUMP_BASE));
            end else begin
                rd = 1 + pick(15);               // Load then a dependent op whose result is stored
                gen_lw(rd, pick(DUMP_BASE));
                gen_r(pick(10), rd, rd, rs2);
                gen_sw(rd, pick(DUMP_BASE));
            end
            last_rd = rd;
        end
        for (int r = 0; r < 16; r++) gen_sw(r, DUMP_BASE + r);   // Register dump
    endtask

    // ============================================================
    // Checks
    // ============================================================
    task automatic report_value(string name, rv_core_pkg::word_t exp, rv_core_pkg::word_t got);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        value_errs++;
    endtask

    task automatic check_idle();
        if (dmem_read !== 1'b0 || dmem_write !== 1'b0) begin
            $display("Data strobe active around reset at %0t", $time);
            other_errs++;
        end
        if (imem_addr !== `RV_RESET_PC) report_value("imem_addr", `RV_RESET_PC, imem_addr);
    endtask

    task automatic check_fetch();
        if (imem_addr !== prev_pc) begin
            if (imem_addr !== prev_pc + 32'd4) begin
                report_value("imem_addr", prev_pc + 32'd4, imem_addr);
            end
            prev_pc  = imem_addr;
            hold_cnt = 0;
        end else begin
            hold_cnt++;
            if (hold_cnt > 1) begin                // A stall is a single cycle
                $display("Fetch address held for %0d cycles at %0t", hold_cnt + 1, $time);
                other_errs++;
            end
        end
    endtask

    task automatic check_mem_port();
        rv_core_pkg::word_t ea;
        rv_core_pkg::word_t ed;
        if (dmem_write) begin
            if (exp_st_addr.size() == 0) begin
                $display("Unexpected store to %h after the last expected one", dmem_addr);
                other_errs++;
            end else begin
                ea = exp_st_addr.pop_front();
                ed = exp_st_data.pop_front();
                if (dmem_addr !== ea) report_value("dmem_addr", ea, dmem_addr);
                if (dmem_wdata !== ed) report_value("dmem_wdata", ed, dmem_wdata);
            end
            n_stores++;
            if (dmem_addr < DMEM_WORDS * 4) dmem[dmem_addr[7:2]] = dmem_wdata;
        end
        if (dmem_read) begin
            if (exp_ld_addr.size() == 0) begin
                $display("Unexpected load from %h at %0t", dmem_addr, $time);
                other_errs++;
            end else begin
                ea = exp_ld_addr.pop_front();
                if (dmem_addr !== ea) report_value("dmem_addr", ea, dmem_addr);
            end
        end
    endtask

    // Outputs are sampled half a cycle after the edge that moved them
    always @(negedge clk) begin
        if (rst) begin
            check_idle();
        end else if (mon_on) begin
            check_fetch();
            check_mem_port();
        end
    end

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int cycles;
        rst        = 1'b1;
        mon_on     = 1'b0;
        seed       = 32'hcd69;
        n_instr    = 0;
        n_stores   = 0;
        value_errs = 0;
        other_errs = 0;
        hold_cnt   = 0;
        prev_pc    = `RV_RESET_PC;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = $random(seed);
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = NOP;
        for (int r = 0; r < 16; r++) model_reg[r] = '0;
        build_program();
        total_stores = exp_st_addr.size();

        repeat (16) @(posedge clk);
        #DRIVE_DLY rst = 1'b0;
        @(negedge clk);
        check_idle();                             // First cycle out of reset
        @(posedge clk);
        #DRIVE_DLY mon_on = 1'b1;

        cycles = 0;
        while (n_stores < total_stores && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (n_stores < total_stores) begin
            $display("Timeout with %0d of %0d stores seen", n_stores, total_stores);
            other_errs++;
        end
        repeat (20) @(posedge clk);               // Room for any stray store
        if (exp_ld_addr.size() != 0) begin
            $display("%0d expected loads never reached the data port", exp_ld_addr.size());
            other_errs++;
        end
        $display("Errors: value %0d, other %0d; stores %0d of %0d",
                 value_errs, other_errs, n_stores, total_stores);
        if (value_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
